//--- common/intr_cfg.svh
/*
 * interrupt block configuration
 * word addresses and widths of the local I/O bus
 */
`ifndef INTR_CFG_SVH
`define INTR_CFG_SVH

// bus widths, address is the word address (byte bits 15:2)
`define INTR_ADR_W  14
`define INTR_DATA_W 32

// interrupter registers
`define SYS_INT_ENABLE 14'h3E80
`define SYS_INT_STATUS 14'h3E81

// compare-match timer registers
// ctrl bit 0 runs the timer
`define SYS_TMR_CTRL  14'h3E90
`define SYS_TMR_CMP   14'h3E91
// read only
`define SYS_TMR_COUNT 14'h3E92

`endif

//--- common/io_pkg.sv
/*
 * local I/O bus types
 * request struct shared by every device on the bus, plus interrupt source bits
 */
`include "intr_cfg.svh"

package io_pkg;

	// register field types
	typedef logic [`INTR_ADR_W-1:0]  io_adr_t;
	typedef logic [`INTR_DATA_W-1:0] io_data_t;

	// one cycle of bus request
	// write lands at the edge, read data comes one cycle after radr_en
	typedef struct packed {
		logic     we;
		io_adr_t  wadr;
		io_data_t wdata;
		io_adr_t  radr;
		logic     radr_en;
	} io_req_t;

	// interrupt sources, same layout as enable and status registers
	typedef struct packed {
		logic int0;
		logic tmr;
	} int_src_t;

endpackage

//--- source/pulse_sync.sv
/*
 * level synchronizer with rising-edge one-shot
 * two flops against metastability, a third one for the edge
 */
`timescale 1ns/1ps

module pulse_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic async_in,
	output logic pulse
);

	logic sync_1;
	logic sync_2;
	logic sync_3;

	// shift the pin level through the chain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			sync_3 <= 1'b0;
		end else begin
			sync_1 <= async_in;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
		end
	end

	// high for one cycle after a low to high change
	assign pulse = sync_2 & ~sync_3;

endmodule

//--- timer/io_timer.sv
/*
 * compare-match timer on the local I/O bus
 * free-running count, wraps to 0 and pulses when it equals compare
 */
`timescale 1ns/1ps
`include "intr_cfg.svh"

module io_timer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  io_pkg::io_req_t         io_req,
	output logic [`INTR_DATA_W-1:0] rdata,
	output logic                    tmr_pulse
);
	import io_pkg::*;

	// address decode
	logic     we_ctrl;
	logic     we_cmp;
	logic     re_ctrl;
	logic     re_cmp;
	logic     re_count;

	// registers
	logic     run;
	io_data_t cmp_val;
	io_data_t count;

	// count sampled at the read strobe
	io_data_t count_snap;

	// registered read selects
	logic     rsel_ctrl;
	logic     rsel_cmp;
	logic     rsel_count;

	assign we_ctrl  = io_req.we      & (io_req.wadr == `SYS_TMR_CTRL);
	assign we_cmp   = io_req.we      & (io_req.wadr == `SYS_TMR_CMP);
	assign re_ctrl  = io_req.radr_en & (io_req.radr == `SYS_TMR_CTRL);
	assign re_cmp   = io_req.radr_en & (io_req.radr == `SYS_TMR_CMP);
	assign re_count = io_req.radr_en & (io_req.radr == `SYS_TMR_COUNT);

	// control and compare, compare comes out of reset all ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run     <= 1'b0;
			cmp_val <= '1;
		end else begin
			if (we_ctrl) begin
				run <= io_req.wdata[0];
			end
			if (we_cmp) begin
				cmp_val <= io_req.wdata;
			end
		end
	end

	// match pulse for the cycle where count sits on compare
	assign tmr_pulse = run & (count == cmp_val);

	// count holds its value while stopped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (tmr_pulse) begin
			count <= '0;
		end else if (run) begin
			count <= count + 1'b1;
		end
	end

	// read returns the count of the strobe cycle
	always_ff @(posedge clk) begin
		if (re_count) begin
			count_snap <= count;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsel_ctrl  <= 1'b0;
			rsel_cmp   <= 1'b0;
			rsel_count <= 1'b0;
		end else begin
			rsel_ctrl  <= re_ctrl;
			rsel_cmp   <= re_cmp;
			rsel_count <= re_count;
		end
	end

	// head of the read chain, zero when nothing of ours is selected
	always_comb begin
		rdata = '0;
		if (rsel_ctrl) begin
			rdata[0] = run;
		end else if (rsel_cmp) begin
			rdata = cmp_val;
		end else if (rsel_count) begin
			rdata = count_snap;
		end
	end

endmodule

//--- interrupter/interrupter.sv
/*
 * machine-level interrupter
 * enable and sticky status per source, global level and its one-shot
 */
`timescale 1ns/1ps
`include "intr_cfg.svh"

module interrupter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  io_pkg::io_req_t         io_req,
	input  io_pkg::int_src_t        src_pulse,
	input  logic                    csr_meie,
	input  logic [`INTR_DATA_W-1:0] rdata_in,
	output logic [`INTR_DATA_W-1:0] rdata,
	output logic                    g_interrupt,
	output logic                    g_interrupt_1shot
);
	import io_pkg::*;

	// address decode
	logic     we_enable;
	logic     we_status;
	logic     re_enable;
	logic     re_status;

	// registers
	int_src_t int_enable;
	int_src_t int_status;

	// per source set and clear requests
	int_src_t set_vec;
	int_src_t clr_vec;

	// edge detect of the global level
	logic     g_interrupt_dly;

	// registered read selects
	logic     rsel_enable;
	logic     rsel_status;

	assign we_enable = io_req.we      & (io_req.wadr == `SYS_INT_ENABLE);
	assign we_status = io_req.we      & (io_req.wadr == `SYS_INT_STATUS);
	assign re_enable = io_req.radr_en & (io_req.radr == `SYS_INT_ENABLE);
	assign re_status = io_req.radr_en & (io_req.radr == `SYS_INT_STATUS);

	// only the low two bits are kept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			int_enable <= '0;
		end else if (we_enable) begin
			int_enable <= int_src_t'(io_req.wdata[1:0]);
		end
	end

	// a pulse counts only with meie and its own enable bit
	assign set_vec = csr_meie ? int_src_t'(src_pulse & int_enable) : '0;

	// writing 0 to a status bit clears it, writing 1 leaves it alone
	assign clr_vec = we_status ? int_src_t'(~io_req.wdata[1:0]) : '0;

	// sticky status, clear wins over a set in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			int_status <= '0;
		end else begin
			int_status <= int_src_t'((int_status | set_vec) & ~clr_vec);
		end
	end

	// global level straight from the status bits
	assign g_interrupt = |int_status;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			g_interrupt_dly <= 1'b0;
		end else begin
			g_interrupt_dly <= g_interrupt;
		end
	end

	// first cycle of the level only
	assign g_interrupt_1shot = g_interrupt & ~g_interrupt_dly;

	// read strobe this cycle, data next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsel_enable <= 1'b0;
			rsel_status <= 1'b0;
		end else begin
			rsel_enable <= re_enable;
			rsel_status <= re_status;
		end
	end

	// last device of the read chain
	// anything not ours comes through from rdata_in
	always_comb begin
		rdata = rdata_in;
		if (rsel_enable) begin
			rdata      = '0;
			rdata[1:0] = int_enable;
		end else if (rsel_status) begin
			rdata      = '0;
			rdata[1:0] = int_status;
		end
	end

endmodule

//--- source/intr_top.sv
/*
 * interrupt block top level
 * pin synchronizer and timer feeding the interrupter on one I/O bus
 */
`timescale 1ns/1ps
`include "intr_cfg.svh"

module intr_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  io_pkg::io_req_t         io_req,
	input  logic                    interrupt_0,
	input  logic                    csr_meie,
	output logic [`INTR_DATA_W-1:0] io_rdata,
	output logic                    g_interrupt,
	output logic                    g_interrupt_1shot
);
	import io_pkg::*;

	logic     int0_pulse;
	logic     tmr_pulse;
	int_src_t src_pulse;

	// timer read data into the chain
	io_data_t tmr_rdata;

	// external pin to one-cycle pulse
	pulse_sync int0_sync_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.async_in (interrupt_0),
		.pulse    (int0_pulse)
	);

	io_timer timer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.io_req    (io_req),
		.rdata     (tmr_rdata),
		.tmr_pulse (tmr_pulse)
	);

	assign src_pulse = '{int0: int0_pulse, tmr: tmr_pulse};

	// interrupter closes the read chain
	interrupter intr_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.io_req            (io_req),
		.src_pulse         (src_pulse),
		.csr_meie          (csr_meie),
		.rdata_in          (tmr_rdata),
		.rdata             (io_rdata),
		.g_interrupt       (g_interrupt),
		.g_interrupt_1shot (g_interrupt_1shot)
	);

endmodule

//--- verif/intr_tb.sv
/*
 * interrupt block testbench
 * bus tasks and LCG stimulus, a cycle model checked by assertions
 */
`timescale 1ns/1ps
`include "intr_cfg.svh"

module intr_tb;
	import io_pkg::*;

	// all tests together run a few hundred cycles
	localparam int MAX_CYCLES = 3000;

	logic        clk;
	logic        rst_n;
	io_req_t     io_req;
	logic        interrupt_0;
	logic        csr_meie;
	logic [31:0] io_rdata;
	logic        g_interrupt;
	logic        g_interrupt_1shot;
	logic [31:0] lcg_state = 32'h35af;
	int          cycle_count = 0;

	// expected state
	int_src_t    exp_enable;
	int_src_t    exp_status;
	logic [2:0]  exp_pin_hist;
	logic        exp_run;
	logic [31:0] exp_cmp;
	logic [31:0] exp_count;
	logic [31:0] exp_count_snap;
	logic        exp_rd_valid;
	logic [13:0] exp_rd_adr;
	logic        exp_g_dly;
	logic        exp_int0_pulse;
	logic        exp_tmr_pulse;
	logic        exp_g;
	logic [31:0] exp_rdata;

	intr_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("run reached %0d cycles without finishing the tests", MAX_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_enable     <= '0;
			exp_status     <= '0;
			exp_pin_hist   <= '0;
			exp_run        <= 1'b0;
			exp_cmp        <= '1;
			exp_count      <= '0;
			exp_count_snap <= '0;
			exp_rd_valid   <= 1'b0;
			exp_rd_adr     <= '0;
			exp_g_dly      <= 1'b0;
		end else begin
			// pin level as seen at each edge
			exp_pin_hist <= {exp_pin_hist[1:0], interrupt_0};
			exp_g_dly    <= exp_g;
			if (io_req.we && io_req.wadr == `SYS_INT_ENABLE)
				exp_enable <= int_src_t'(io_req.wdata[1:0]);
			if (io_req.we && io_req.wadr == `SYS_TMR_CTRL)
				exp_run <= io_req.wdata[0];
			if (io_req.we && io_req.wadr == `SYS_TMR_CMP)
				exp_cmp <= io_req.wdata;
			// set first, a clear later in the block overrides it
			if (csr_meie && exp_int0_pulse && exp_enable.int0)
				exp_status.int0 <= 1'b1;
			if (csr_meie && exp_tmr_pulse && exp_enable.tmr)
				exp_status.tmr <= 1'b1;
			if (io_req.we && io_req.wadr == `SYS_INT_STATUS && !io_req.wdata[1])
				exp_status.int0 <= 1'b0;
			if (io_req.we && io_req.wadr == `SYS_INT_STATUS && !io_req.wdata[0])
				exp_status.tmr <= 1'b0;
			if (exp_tmr_pulse)
				exp_count <= '0;
			else if (exp_run)
				exp_count <= exp_count + 32'd1;
			if (io_req.radr_en && io_req.radr == `SYS_TMR_COUNT)
				exp_count_snap <= exp_count;
			exp_rd_valid <= io_req.radr_en;
			exp_rd_adr   <= io_req.radr;
		end
	end

	always_comb begin
		exp_int0_pulse = exp_pin_hist[1] & ~exp_pin_hist[2];
		exp_tmr_pulse  = exp_run && exp_count == exp_cmp;
		exp_g          = exp_status != '0;
		exp_rdata      = '0;
		if (exp_rd_valid) begin
			case (exp_rd_adr)
				`SYS_INT_ENABLE: exp_rdata = {30'd0, exp_enable};
				`SYS_INT_STATUS: exp_rdata = {30'd0, exp_status};
				`SYS_TMR_CTRL:   exp_rdata = {31'd0, exp_run};
				`SYS_TMR_CMP:    exp_rdata = exp_cmp;
				`SYS_TMR_COUNT:  exp_rdata = exp_count_snap;
				default:         exp_rdata = '0;
			endcase
		end
	end

	// compared mid cycle, where inputs and model are settled
	assert property (@(negedge clk) disable iff (!rst_n) io_rdata == exp_rdata)
		else report_value("io_rdata", io_rdata, exp_rdata);
	assert property (@(negedge clk) disable iff (!rst_n) g_interrupt == exp_g)
		else report_value("g_interrupt", 32'(g_interrupt), 32'(exp_g));
	assert property (@(negedge clk) disable iff (!rst_n)
		g_interrupt_1shot == (exp_g && !exp_g_dly))
		else report_value("g_interrupt_1shot", 32'(g_interrupt_1shot),
			32'(exp_g && !exp_g_dly));

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp)
			else report_value(name, got, exp);
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic write_reg(input logic [13:0] adr, input logic [31:0] data);
		@(posedge clk);
		io_req.we    <= 1'b1;
		io_req.wadr  <= adr;
		io_req.wdata <= data;
		@(posedge clk);
		io_req.we    <= 1'b0;
	endtask

	// data shows up in the cycle after the strobe
	task automatic read_reg(input logic [13:0] adr, output logic [31:0] data);
		@(posedge clk);
		io_req.radr_en <= 1'b1;
		io_req.radr    <= adr;
		@(posedge clk);
		io_req.radr_en <= 1'b0;
		@(negedge clk);
		data = io_rdata;
	endtask

	task automatic pulse_pin();
		@(posedge clk);
		interrupt_0 <= 1'b1;
		repeat (4 + next_random() % 8) @(posedge clk);
		interrupt_0 <= 1'b0;
		repeat (4 + next_random() % 8) @(posedge clk);
	endtask

	task automatic wait_for_interrupt();
		@(negedge clk);
		while (!g_interrupt)
			@(negedge clk);
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] value;
		int          edges;
		int          t_last;
		rst_n       = 1'b0;
		io_req      = '0;
		interrupt_0 = 1'b0;
		csr_meie    = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_eq("g_interrupt", 32'(g_interrupt), 0);
		check_eq("g_interrupt_1shot", 32'(g_interrupt_1shot), 0);
		check_eq("io_rdata", io_rdata, 0);

		// readback, enable keeps two bits
		value = next_random();
		write_reg(`SYS_INT_ENABLE, value);
		read_reg(`SYS_INT_ENABLE, data);
		check_eq("int_enable", data, {30'd0, value[1:0]});
		value = next_random();
		write_reg(`SYS_TMR_CMP, value);
		read_reg(`SYS_TMR_CMP, data);
		check_eq("tmr_cmp", data, value);

		// pin edge, sampled at the next rising edge
		write_reg(`SYS_INT_ENABLE, 32'h2);
		csr_meie    <= 1'b1;
		interrupt_0 <= 1'b1;
		@(posedge clk);
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end while (!g_interrupt);
		check_eq("edges from pin sample to g_interrupt", edges, 2);
		check_eq("g_interrupt_1shot", 32'(g_interrupt_1shot), 1);
		@(negedge clk);
		check_eq("g_interrupt_1shot", 32'(g_interrupt_1shot), 0);
		read_reg(`SYS_INT_STATUS, data);
		check_eq("int_status", data, 2);
		@(posedge clk);
		interrupt_0 <= 1'b0;

		// masked by meie, then by the enable bits
		write_reg(`SYS_INT_STATUS, 32'h0);
		csr_meie <= 1'b0;
		write_reg(`SYS_INT_ENABLE, 32'h3);
		write_reg(`SYS_TMR_CMP, 32'd6 + next_random() % 4);
		write_reg(`SYS_TMR_CTRL, 32'h1);
		read_reg(`SYS_TMR_CTRL, data);
		check_eq("tmr_ctrl", data, 1);
		pulse_pin();
		write_reg(`SYS_INT_ENABLE, 32'h0);
		csr_meie <= 1'b1;
		pulse_pin();
		write_reg(`SYS_TMR_CTRL, 32'h0);
		read_reg(`SYS_INT_STATUS, data);
		check_eq("int_status", data, 0);

		// both bits set, then cleared one at a time
		write_reg(`SYS_INT_ENABLE, 32'h3);
		pulse_pin();
		write_reg(`SYS_TMR_CTRL, 32'h1);
		read_reg(`SYS_INT_STATUS, data);
		while (data != 32'h3)
			read_reg(`SYS_INT_STATUS, data);
		write_reg(`SYS_TMR_CTRL, 32'h0);
		write_reg(`SYS_INT_STATUS, 32'h3);
		read_reg(`SYS_INT_STATUS, data);
		check_eq("int_status", data, 3);
		write_reg(`SYS_INT_STATUS, 32'h1);
		read_reg(`SYS_INT_STATUS, data);
		check_eq("int_status", data, 1);
		check_eq("g_interrupt", 32'(g_interrupt), 1);
		write_reg(`SYS_INT_STATUS, 32'h2);
		read_reg(`SYS_INT_STATUS, data);
		check_eq("int_status", data, 0);
		check_eq("g_interrupt", 32'(g_interrupt), 0);

		// compare above the held count so the first match is reached
		write_reg(`SYS_INT_ENABLE, 32'h1);
		read_reg(`SYS_TMR_COUNT, data);
		value = data + 32'd5 + next_random() % 8;
		write_reg(`SYS_TMR_CMP, value);
		write_reg(`SYS_TMR_CTRL, 32'h1);
		wait_for_interrupt();
		t_last = cycle_count;
		repeat (3) begin
			write_reg(`SYS_INT_STATUS, 32'h0);
			read_reg(`SYS_TMR_COUNT, data);
			wait_for_interrupt();
			check_eq("timer period", cycle_count - t_last, value + 32'd1);
			t_last = cycle_count;
		end
		write_reg(`SYS_TMR_CTRL, 32'h0);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- intr_sys.f
+incdir+common
common/io_pkg.sv
source/pulse_sync.sv
timer/io_timer.sv
interrupter/interrupter.sv
source/intr_top.sv
verif/intr_tb.sv

//--- Makefile
# Verilator flow for the interrupt block

TOOL       = verilator
TB_TOP     = intr_tb
RTL_TOP    = intr_top
FILELIST   = intr_sys.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the simulator's exit status is the test result
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
